/* hw/montPkg.sv */
package montPkg;

  // carry-select segment width of the wide adder.
  localparam int segWidth = 64;

  // controller states of the Montgomery loop.
  typedef enum logic [3:0] {
    stIdle,
    stTestA,
    stAddB,
    stWaitB,
    stTestOdd,
    stAddM,
    stWaitM,
    stShift,
    stSubM,
    stWaitSub,
    stFinish
  } montState;

  // adder function.
  typedef enum logic {
    opAdd,
    opSub
  } adderOp;

  // second adder operand.
  typedef enum logic {
    selB,
    selM
  } operandSel;

endpackage

/* hw/mpAdder.sv */
`timescale 1ns/10ps

module mpAdder #(
  parameter int width = 1027
) (
  input  logic             clk,
  input  logic             start,
  input  montPkg::adderOp  op,
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  output logic [width:0]   result,
  output logic             done
);

  localparam int numSeg = (width + montPkg::segWidth - 1) / montPkg::segWidth;

  logic [width-1:0]  bMux;
  logic [width-1:0]  sumC0;
  logic [width-1:0]  sumC1;
  logic [numSeg-1:0] carryC0;
  logic [numSeg-1:0] carryC1;
  logic [width-1:0]  sumC0Reg;
  logic [width-1:0]  sumC1Reg;
  logic [numSeg-1:0] carryC0Reg;
  logic [numSeg-1:0] carryC1Reg;
  montPkg::adderOp   opReg;
  logic              subReg;
  logic [numSeg:0]   carryIn;
  logic [width-1:0]  sumSel;

  // subtraction is a + ~b + 1, the +1 enters as carry-in of segment 0.
  assign bMux = (op == montPkg::opSub) ? ~b : b;

  for (genvar s = 0; s < numSeg; s++) begin : gSeg
    localparam int segLo = s * montPkg::segWidth;
    localparam int segHi = (segLo + montPkg::segWidth < width) ?
                           segLo + montPkg::segWidth - 1 : width - 1;

    // both carry-in versions of this segment.
    assign {carryC0[s], sumC0[segHi:segLo]} = a[segHi:segLo] + bMux[segHi:segLo];
    assign {carryC1[s], sumC1[segHi:segLo]} = a[segHi:segLo] + bMux[segHi:segLo] + 1'b1;

    // after the register, the incoming carry picks the version.
    assign sumSel[segHi:segLo] = carryIn[s] ? sumC1Reg[segHi:segLo] : sumC0Reg[segHi:segLo];
    assign carryIn[s+1] = carryIn[s] ? carryC1Reg[s] : carryC0Reg[s];
  end

  always_ff @(posedge clk) begin
    sumC0Reg   <= sumC0;
    sumC1Reg   <= sumC1;
    carryC0Reg <= carryC0;
    carryC1Reg <= carryC1;
    opReg      <= op;
    done       <= start; // one register stage.
  end

  assign subReg     = (opReg == montPkg::opSub);
  assign carryIn[0] = subReg;

  // top bit is carry for add, borrow for sub.
  assign result = {subReg ^ carryIn[numSeg], sumSel};

endmodule

/* hw/bitCounter.sv */
`timescale 1ns/10ps

module bitCounter #(
  parameter int width = 1024
) (
  input  logic clk,
  input  logic reset,
  input  logic countLoad,
  input  logic countStep,
  output logic lastBit
);

  localparam int cntWidth = $clog2(width + 1);

  logic [cntWidth-1:0] count; // iterations still to run.

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (countLoad) begin
      count <= cntWidth'(width);
    end else if (countStep && count != '0) begin
      count <= count - 1'b1;
    end
  end

  // high for the whole final iteration.
  assign lastBit = (count == cntWidth'(1));

endmodule

/* hw/montControl.sv */
`timescale 1ns/10ps

module montControl (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               aBit,
  input  logic               sumOdd,
  input  logic               addDone,
  input  logic               borrow,
  input  logic               lastBit,
  output logic               loadOperands,
  output logic               countLoad,
  output logic               countStep,
  output logic               addStart,
  output montPkg::adderOp    addOp,
  output montPkg::operandSel addSel,
  output logic               takeSum,
  output logic               shiftSum,
  output logic               finalSelect,
  output logic               done,
  output logic               busy
);

  montPkg::montState state;
  montPkg::montState nextState;

  always_ff @(posedge clk) begin
    if (reset) state <= montPkg::stIdle;
    else       state <= nextState;
  end

  always_comb begin
    nextState    = state;
    loadOperands = 1'b0;
    countLoad    = 1'b0;
    countStep    = 1'b0;
    addStart     = 1'b0;
    addOp        = montPkg::opAdd;
    addSel       = montPkg::selB;
    takeSum      = 1'b0;
    shiftSum     = 1'b0;
    finalSelect  = 1'b0;
    case (state)
      montPkg::stIdle: begin
        if (start) begin
          loadOperands = 1'b1;
          countLoad    = 1'b1;
          nextState    = montPkg::stTestA;
        end
      end
      montPkg::stTestA: begin
        // sum is unchanged when b is skipped, so test parity here too.
        if (aBit)        nextState = montPkg::stAddB;
        else if (sumOdd) nextState = montPkg::stAddM;
        else             nextState = montPkg::stShift;
      end
      montPkg::stAddB: begin
        addStart  = 1'b1;
        addSel    = montPkg::selB;
        nextState = montPkg::stWaitB;
      end
      montPkg::stWaitB: begin
        takeSum = addDone;
        if (addDone) nextState = montPkg::stTestOdd;
      end
      montPkg::stTestOdd: begin
        // launch the modulus add straight from the test.
        addStart  = sumOdd;
        addSel    = montPkg::selM;
        nextState = sumOdd ? montPkg::stWaitM : montPkg::stShift;
      end
      montPkg::stAddM: begin
        addStart  = 1'b1;
        addSel    = montPkg::selM;
        nextState = montPkg::stWaitM;
      end
      montPkg::stWaitM: begin
        takeSum = addDone;
        if (addDone) nextState = montPkg::stShift;
      end
      montPkg::stShift: begin
        shiftSum  = 1'b1;
        countStep = 1'b1;
        nextState = lastBit ? montPkg::stSubM : montPkg::stTestA;
      end
      montPkg::stSubM: begin
        addStart  = 1'b1;
        addOp     = montPkg::opSub;
        addSel    = montPkg::selM;
        nextState = montPkg::stWaitSub;
      end
      montPkg::stWaitSub: begin
        addOp       = montPkg::opSub;
        takeSum     = addDone && !borrow; // keep the difference only without borrow.
        finalSelect = addDone;
        if (addDone) nextState = montPkg::stFinish;
      end
      montPkg::stFinish: nextState = montPkg::stIdle;
      default:           nextState = montPkg::stIdle;
    endcase
  end

  assign done = (state == montPkg::stFinish);
  assign busy = (state != montPkg::stIdle);

endmodule

/* hw/montDatapath.sv */
`timescale 1ns/10ps

module montDatapath #(
  parameter int width = 1024
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [width-1:0]   a,
  input  logic [width-1:0]   b,
  input  logic [width-1:0]   modulus,
  input  logic               loadOperands,
  input  logic               addStart,
  input  montPkg::adderOp    addOp,
  input  montPkg::operandSel addSel,
  input  logic               takeSum,
  input  logic               shiftSum,
  input  logic               finalSelect,
  output logic               aBit,
  output logic               sumOdd,
  output logic               addDone,
  output logic               borrow,
  output logic [width-1:0]   result
);

  // sum stays below 2*modulus, and sum + b + modulus needs two extra bits.
  localparam int addWidth = width + 3;

  logic [width-1:0]  aShift;
  logic [width-1:0]  bReg;
  logic [width-1:0]  modReg;
  logic [width+1:0]  sum;
  logic [width+1:0]  sumNext;
  logic [width-1:0]  operand;
  logic [addWidth-1:0] addA;
  logic [addWidth-1:0] addB;
  logic [addWidth:0]   addResult;

  assign operand = (addSel == montPkg::selM) ? modReg : bReg;
  assign addA    = {1'b0, sum};
  assign addB    = {3'b000, operand};

  mpAdder #(
    .width(addWidth)
  ) mpAdder_i (
    .clk    (clk),
    .start  (addStart),
    .op     (addOp),
    .a      (addA),
    .b      (addB),
    .result (addResult),
    .done   (addDone)
  );

  // the adder result lands in the sum register in the addDone cycle.
  assign sumNext = takeSum ? addResult[width+1:0] : sum;

  always_ff @(posedge clk) begin
    if (loadOperands) begin
      aShift <= a;
      bReg   <= b;
      modReg <= modulus;
    end else if (shiftSum) begin
      aShift <= aShift >> 1; // next bit of a to the bottom.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum    <= '0;
      result <= '0;
    end else begin
      if (loadOperands) begin
        sum <= '0;
      end else if (shiftSum) begin
        sum <= sum >> 1; // exact, the sum is even here.
      end else begin
        sum <= sumNext;
      end
      // without borrow sumNext holds the difference, else the old sum.
      if (finalSelect) begin
        result <= sumNext[width-1:0];
      end
    end
  end

  assign aBit   = aShift[0];
  assign sumOdd = sum[0];
  assign borrow = addResult[addWidth]; // borrow of the final subtraction.

endmodule

/* hw/montMul.sv */
`timescale 1ns/10ps

module montMul #(
  parameter int width = 1024
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  logic [width-1:0] modulus,
  output logic [width-1:0] result,
  output logic             done,
  output logic             busy
);

  logic               loadOperands;
  logic               countLoad;
  logic               countStep;
  logic               addStart;
  montPkg::adderOp    addOp;
  montPkg::operandSel addSel;
  logic               takeSum;
  logic               shiftSum;
  logic               finalSelect;
  logic               aBit;
  logic               sumOdd;
  logic               addDone;
  logic               borrow;
  logic               lastBit;

  montControl montControl_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .aBit         (aBit),
    .sumOdd       (sumOdd),
    .addDone      (addDone),
    .borrow       (borrow),
    .lastBit      (lastBit),
    .loadOperands (loadOperands),
    .countLoad    (countLoad),
    .countStep    (countStep),
    .addStart     (addStart),
    .addOp        (addOp),
    .addSel       (addSel),
    .takeSum      (takeSum),
    .shiftSum     (shiftSum),
    .finalSelect  (finalSelect),
    .done         (done),
    .busy         (busy)
  );

  bitCounter #(
    .width(width)
  ) bitCounter_i (
    .clk       (clk),
    .reset     (reset),
    .countLoad (countLoad),
    .countStep (countStep),
    .lastBit   (lastBit)
  );

  montDatapath #(
    .width(width)
  ) montDatapath_i (
    .clk          (clk),
    .reset        (reset),
    .a            (a),
    .b            (b),
    .modulus      (modulus),
    .loadOperands (loadOperands),
    .addStart     (addStart),
    .addOp        (addOp),
    .addSel       (addSel),
    .takeSum      (takeSum),
    .shiftSum     (shiftSum),
    .finalSelect  (finalSelect),
    .aBit         (aBit),
    .sumOdd       (sumOdd),
    .addDone      (addDone),
    .borrow       (borrow),
    .result       (result)
  );

endmodule

/* verif/montMul_properties.sv */
`timescale 1ns/10ps

module montMulProperties (
  input logic clk,
  input logic reset,
  input logic done,
  input logic busy,
  input logic addStart,
  input logic addDone
);

  int failCount = 0; // count of failed assertions.

  // done is a strobe.
  property doneSingleCycle;
    @(posedge clk) disable iff (reset) done |=> !done;
  endproperty

  property adderLatency;
    @(posedge clk) disable iff (reset) addStart |=> addDone;
  endproperty

  property busyDropsAfterDone;
    @(posedge clk) disable iff (reset) done |=> !busy;
  endproperty

  doneCheck: assert property (doneSingleCycle) else begin
    failCount++;
    $error("done held high for two cycles");
  end

  addCheck: assert property (adderLatency) else begin
    failCount++;
    $error("adder done missing one cycle after start");
  end

  busyCheck: assert property (busyDropsAfterDone) else begin
    failCount++;
    $error("busy still high after done");
  end

endmodule

bind montMul montMulProperties montMulProperties_i (
  .clk      (clk),
  .reset    (reset),
  .done     (done),
  .busy     (busy),
  .addStart (addStart),
  .addDone  (addDone)
);

/* verif/montMulTb.sv */
`timescale 1ns/10ps

module montMulTb;

  localparam int width     = 256;
  localparam int numTests  = 60;                 // upper bound on operations started.
  localparam int maxCycles = 6 * width + 10;     // worst case latency of one operation.

  logic             clk;
  logic             reset;
  logic             start;
  logic [width-1:0] a;
  logic [width-1:0] b;
  logic [width-1:0] modulus;
  logic [width-1:0] result;
  logic             done;
  logic             busy;

  int errorCount = 0;
  int testCount  = 0;
  int donePulses = 0;

  montMul #(
    .width(width)
  ) montMul_i (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .a       (a),
    .b       (b),
    .modulus (modulus),
    .result  (result),
    .done    (done),
    .busy    (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) begin
    if (done) donePulses++;
  end

  function automatic logic [width-1:0] randWide();
    logic [width-1:0] r;
    for (int i = 0; i < width / 32; i++) r[32*i +: 32] = $urandom();
    return r;
  endfunction

  function automatic logic [width-1:0] randModulus();
    logic [width-1:0] m;
    m = randWide();
    m[width-1] = 1'b1; // full size and odd.
    m[0]       = 1'b1;
    return m;
  endfunction

  // a*b*2^-width mod m where 2^-width is the width-th power of the inverse of 2.
  function automatic logic [width-1:0] montRef(input logic [width-1:0] x, input logic [width-1:0] y,
                                               input logic [width-1:0] m);
    logic [2*width+1:0] mw;
    logic [2*width+1:0] inv2;
    logic [2*width+1:0] rInv;
    logic [2*width+1:0] prod;
    mw   = m;
    inv2 = (mw + 1) >> 1;
    rInv = 1;
    for (int i = 0; i < width; i++) rInv = (rInv * inv2) % mw;
    prod = x;
    prod = (prod * y) % mw;
    prod = (prod * rInv) % mw;
    return prod[width-1:0];
  endfunction

  task automatic driveStart(input logic [width-1:0] x, input logic [width-1:0] y,
                            input logic [width-1:0] m);
    @(posedge clk);
    #2;
    a       = x;
    b       = y;
    modulus = m;
    start   = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic waitDone(output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < maxCycles) begin
      @(negedge clk);
      if (done) seen = 1'b1;
      else cycles++;
    end
    assert (seen) else begin
      errorCount++;
      $display("no done pulse within %0d cycles, run stopped waiting at %0t", maxCycles, $time);
    end
  endtask

  task automatic checkResult(input logic [width-1:0] x, input logic [width-1:0] y,
                             input logic [width-1:0] m);
    logic [width-1:0] expected;
    expected = montRef(x, y, m);
    assert (result == expected) else begin
      errorCount++;
      $display("MISMATCH at %0t: result got %h expected %h", $time, result, expected);
    end
    assert (result < m) else begin
      errorCount++;
      $display("result %h is not below modulus %h at %0t", result, m, $time);
    end
  endtask

  task automatic runAndCheck(input logic [width-1:0] x, input logic [width-1:0] y,
                             input logic [width-1:0] m);
    bit seen;
    testCount++;
    driveStart(x, y, m);
    waitDone(seen);
    if (seen) checkResult(x, y, m);
  endtask

  // a second start lands mid-operation and must leave no trace.
  task automatic checkIgnoredStart();
    logic [width-1:0] m1;
    logic [width-1:0] m2;
    int pulsesBefore;
    bit seen;
    m1 = randModulus();
    m2 = randModulus();
    testCount++;
    driveStart(randWide() % m1, randWide() % m1, m1);
    pulsesBefore = donePulses;
    // driveStart leaves the operand inputs holding the first triple.
    begin
      logic [width-1:0] x1;
      logic [width-1:0] y1;
      x1 = a;
      y1 = b;
      repeat (4) @(posedge clk);
      #2;
      a       = randWide() % m2;
      b       = randWide() % m2;
      modulus = m2;
      start   = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
      waitDone(seen);
      if (seen) checkResult(x1, y1, m1);
    end
    repeat (30) @(negedge clk);
    assert (donePulses == pulsesBefore + 1 && !busy) else begin
      errorCount++;
      $display("start while busy was not ignored, %0d done pulses seen for one accepted start",
               donePulses - pulsesBefore);
    end
  endtask

  initial begin
    #(longint'(numTests) * maxCycles * 20 + 20000);
    $display("timeout after %0t, tests %0d, errors %0d", $time, testCount, errorCount);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [width-1:0] m;
    void'($urandom(32'h82c60fea));
    reset   = 1'b1;
    start   = 1'b0;
    a       = '0;
    b       = '0;
    modulus = '0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    assert (!done && !busy) else begin
      errorCount++;
      $display("done or busy high after reset at %0t", $time);
    end

    // edge operands.
    m = randModulus();
    runAndCheck('0, randWide() % m, m);
    runAndCheck(randWide() % m, '0, m);
    runAndCheck(width'(1), width'(1), m);

    // operands near the top of the range so the final subtraction fires.
    for (int i = 0; i < 4; i++) begin
      m = {width{1'b1}} - (randWide() & width'(16'hffff));
      m[0] = 1'b1;
      runAndCheck(m - 1 - (randWide() & width'(8'hff)), m - 1 - (randWide() & width'(8'hff)), m);
    end

    for (int i = 0; i < 40; i++) begin
      m = randModulus();
      runAndCheck(randWide() % m, randWide() % m, m);
    end

    checkIgnoredStart();

    // each start goes out in the cycle after the previous done.
    for (int i = 0; i < 3; i++) begin
      m = randModulus();
      runAndCheck(randWide() % m, randWide() % m, m);
    end

    repeat (5) @(posedge clk);
    errorCount += montMul_i.montMulProperties_i.failCount;
    $display("tests %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* flist.f */
hw/montPkg.sv
hw/mpAdder.sv
hw/bitCounter.sv
hw/montControl.sv
hw/montDatapath.sv
hw/montMul.sv
verif/montMul_properties.sv
verif/montMulTb.sv
